// File: design/dmem_router_pkg.sv
//-------------------------------------------------
// Shared definitions for the data memory router
// Bus and port index types
// Port count and address windows
// Response, command and tracker phase encodings
//-------------------------------------------------

package dmem_router_pkg;

    //-------------------------------------------------
    // Bus types
    //-------------------------------------------------

    // Byte address and data on the core and port buses
    typedef logic [31:0] dmem_addr_t;
    typedef logic [31:0] dmem_data_t;

    // Access size, byte / half / word
    typedef logic [1:0]  dmem_width_t;

    //-------------------------------------------------
    // Ports and address map
    //-------------------------------------------------

    // Port 0 is the default target
    localparam int N_PORTS = 5;

    // Port number 0 to 4, and one bit per port
    typedef logic [2:0]         port_idx_t;
    typedef logic [N_PORTS-1:0] port_vec_t;

    // Every window is 64 KiB, upper half of the address compared
    localparam dmem_addr_t PORT_ADDR_MASK = 32'hFFFF_0000;

    // Window patterns for ports 1 to 4
    localparam dmem_addr_t PORT_ADDR_PATTERN [1:N_PORTS-1] = '{
        32'h0001_0000,
        32'h0002_0000,
        32'h0003_0000,
        32'h0004_0000
    };

    //-------------------------------------------------
    // Encodings
    //-------------------------------------------------

    typedef enum logic [1:0] {
        RESP_NOTRDY = 2'b00,
        RESP_RDY_OK = 2'b01,
        RESP_RDY_ER = 2'b10
    } mem_resp_e;

    typedef enum logic {
        CMD_RD = 1'b0,
        CMD_WR = 1'b1
    } mem_cmd_e;

    // Tracker phase, address accepted moves to data
    typedef enum logic {
        PHASE_ADDR = 1'b0,
        PHASE_DATA = 1'b1
    } txn_phase_e;

endpackage

// File: design/dmem_addr_decoder.sv
//-------------------------------------------------
// Address decoder for the data memory router
// Masks the request address and picks the target
// port by priority, port 0 when no window matches
//-------------------------------------------------

`timescale 1ns/100ps

module dmem_addr_decoder (
    // Core request address
    input  dmem_router_pkg::dmem_addr_t addr,
    // Target port of this address
    output dmem_router_pkg::port_idx_t  port_sel
);

    import dmem_router_pkg::*;

    //-------------------------------------------------
    // Window compare
    //-------------------------------------------------

    // Upper address bits, shared by all window compares
    dmem_addr_t addr_masked;

    // One match flag per window, bit 0 unused
    port_vec_t  win_hit;

    assign addr_masked = addr & PORT_ADDR_MASK;

    always_comb begin
        win_hit = '0;
        for (int i = 1; i < N_PORTS; i++) begin
            win_hit[i] = (addr_masked == PORT_ADDR_PATTERN[i]);
        end
    end

    //-------------------------------------------------
    // Priority select
    //-------------------------------------------------

    // Lowest numbered matching window wins
    always_comb begin
        logic found;
        found    = 1'b0;
        port_sel = '0;
        for (int i = 1; i < N_PORTS; i++) begin
            if (!found && win_hit[i]) begin
                found    = 1'b1;
                port_sel = port_idx_t'(i);
            end
        end
        // No window hit leaves the default port 0
    end

endmodule

// File: design/dmem_req_steer.sv
//-------------------------------------------------
// Request steering for the data memory router
// Raises the request of the decoded port and
// returns that port's acknowledge to the core
//-------------------------------------------------

`timescale 1ns/100ps

module dmem_req_steer (
    // Core request strobe
    input  logic                       dmem_req,
    // Decoded target of the current address
    input  dmem_router_pkg::port_idx_t port_sel,
    // Tracker can take a new address this cycle
    input  logic                       addr_open,
    // Acknowledge from each port
    input  dmem_router_pkg::port_vec_t port_req_ack,
    // Request to each port
    output dmem_router_pkg::port_vec_t port_req,
    // Acknowledge back to the core
    output logic                       dmem_req_ack
);

    import dmem_router_pkg::*;

    //-------------------------------------------------
    // Port select
    //-------------------------------------------------

    // One-hot form of the decoded port
    port_vec_t sel_onehot;

    // Acknowledge of the decoded port
    logic      sel_ack;

    always_comb begin
        sel_onehot = '0;
        for (int i = 0; i < N_PORTS; i++) begin
            sel_onehot[i] = (port_sel == port_idx_t'(i));
        end
    end

    //-------------------------------------------------
    // Request fan-out
    //-------------------------------------------------

    // Nothing goes out while the tracker waits on a response
    always_comb begin
        for (int i = 0; i < N_PORTS; i++) begin
            port_req[i] = addr_open & dmem_req & sel_onehot[i];
        end
    end

    //-------------------------------------------------
    // Acknowledge return
    //-------------------------------------------------

    always_comb begin
        sel_ack = 1'b0;
        for (int i = 0; i < N_PORTS; i++) begin
            if (sel_onehot[i]) begin
                sel_ack = port_req_ack[i];
            end
        end
    end

    // Same cycle as the port's acknowledge
    // Held low while the address phase is closed
    assign dmem_req_ack = addr_open & sel_ack;

endmodule

// File: design/dmem_txn_tracker.sv
//-------------------------------------------------
// Transaction tracker for the data memory router
// Address/data phase FSM and captured target port
// Response and read data return from that port
//-------------------------------------------------

`timescale 1ns/100ps

module dmem_txn_tracker (
    input  logic                                                   clk,
    input  logic                                                   rst_n,
    // Core address handshake
    input  logic                                                   dmem_req,
    input  logic                                                   dmem_req_ack,
    // Decoded target of the current address
    input  dmem_router_pkg::port_idx_t                             port_sel,
    // Return path from every port
    input  dmem_router_pkg::dmem_data_t [dmem_router_pkg::N_PORTS-1:0] port_rdata,
    input  dmem_router_pkg::mem_resp_e  [dmem_router_pkg::N_PORTS-1:0] port_resp,
    // Tracker can take a new address this cycle
    output logic                                                   addr_open,
    // Return path to the core
    output dmem_router_pkg::dmem_data_t                            dmem_rdata,
    output dmem_router_pkg::mem_resp_e                             dmem_resp
);

    import dmem_router_pkg::*;

    //-------------------------------------------------
    // State
    //-------------------------------------------------

    txn_phase_e phase_q;

    // Port that owns the outstanding access
    port_idx_t  port_sel_q;

    // Response and data of the owning port
    mem_resp_e  sel_resp;
    dmem_data_t sel_rdata;

    // Address phase completes this cycle
    logic       addr_hs;

    assign addr_hs = dmem_req & dmem_req_ack;

    //-------------------------------------------------
    // Return mux
    //-------------------------------------------------

    // Out of range index reads as an error
    always_comb begin
        sel_resp  = RESP_RDY_ER;
        sel_rdata = '0;
        for (int i = 0; i < N_PORTS; i++) begin
            if (port_sel_q == port_idx_t'(i)) begin
                sel_resp  = port_resp[i];
                sel_rdata = port_rdata[i];
            end
        end
    end

    assign dmem_resp  = sel_resp;
    assign dmem_rdata = sel_rdata;

    // Open when idle, or when the current access ends OK
    // An error response keeps the next address out for a cycle
    assign addr_open = (phase_q == PHASE_ADDR) |
                       ((phase_q == PHASE_DATA) & (sel_resp == RESP_RDY_OK));

    //-------------------------------------------------
    // Phase FSM
    //-------------------------------------------------

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            phase_q    <= PHASE_ADDR;
            port_sel_q <= '0;
        end else begin
            case (phase_q)
                PHASE_ADDR: begin
                    if (addr_hs) begin
                        phase_q    <= PHASE_DATA;
                        port_sel_q <= port_sel;
                    end
                end
                PHASE_DATA: begin
                    case (sel_resp)
                        RESP_RDY_OK: begin
                            // Back-to-back, next access already accepted
                            if (addr_hs) begin
                                port_sel_q <= port_sel;
                            end else begin
                                phase_q <= PHASE_ADDR;
                            end
                        end
                        RESP_RDY_ER: begin
                            phase_q <= PHASE_ADDR;
                        end
                        default: begin
                            // Still waiting on the owning port
                        end
                    endcase
                end
                default: begin
                    phase_q <= PHASE_ADDR;
                end
            endcase
        end
    end

endmodule

// File: design/dmem_router.sv
//-------------------------------------------------
// Data memory router top level
// One core request channel to five memory ports
// Decoder, request steering and transaction tracker
// Shared command/address/data bus to all ports
//-------------------------------------------------

`timescale 1ns/100ps

module dmem_router (
    input  logic                                                   clk,
    input  logic                                                   rst_n,

    //-------------------------------------------------
    // Core side
    //-------------------------------------------------
    input  logic                                                   dmem_req,
    input  dmem_router_pkg::mem_cmd_e                              dmem_cmd,
    input  dmem_router_pkg::dmem_width_t                           dmem_width,
    input  dmem_router_pkg::dmem_addr_t                            dmem_addr,
    input  dmem_router_pkg::dmem_data_t                            dmem_wdata,
    output logic                                                   dmem_req_ack,
    output dmem_router_pkg::dmem_data_t                            dmem_rdata,
    output dmem_router_pkg::mem_resp_e                             dmem_resp,

    //-------------------------------------------------
    // Port side
    //-------------------------------------------------
    // Request and acknowledge, one bit per port
    output dmem_router_pkg::port_vec_t                             port_req,
    input  dmem_router_pkg::port_vec_t                             port_req_ack,
    // Shared bus, seen by every port
    output dmem_router_pkg::mem_cmd_e                              port_cmd,
    output dmem_router_pkg::dmem_width_t                           port_width,
    output dmem_router_pkg::dmem_addr_t                            port_addr,
    output dmem_router_pkg::dmem_data_t                            port_wdata,
    // Return path, indexed by port number
    input  dmem_router_pkg::dmem_data_t [dmem_router_pkg::N_PORTS-1:0] port_rdata,
    input  dmem_router_pkg::mem_resp_e  [dmem_router_pkg::N_PORTS-1:0] port_resp
);

    import dmem_router_pkg::*;

    // Decoded target of the current address
    port_idx_t port_sel;

    // Tracker ready for a new address phase
    logic      addr_open;

    //-------------------------------------------------
    // Address decode
    //-------------------------------------------------

    dmem_addr_decoder u_addr_decoder (
        .addr     (dmem_addr),
        .port_sel (port_sel)
    );

    //-------------------------------------------------
    // Request steering
    //-------------------------------------------------

    dmem_req_steer u_req_steer (
        .dmem_req     (dmem_req),
        .port_sel     (port_sel),
        .addr_open    (addr_open),
        .port_req_ack (port_req_ack),
        .port_req     (port_req),
        .dmem_req_ack (dmem_req_ack)
    );

    //-------------------------------------------------
    // Transaction tracking and response return
    //-------------------------------------------------

    dmem_txn_tracker u_txn_tracker (
        .clk          (clk),
        .rst_n        (rst_n),
        .dmem_req     (dmem_req),
        .dmem_req_ack (dmem_req_ack),
        .port_sel     (port_sel),
        .port_rdata   (port_rdata),
        .port_resp    (port_resp),
        .addr_open    (addr_open),
        .dmem_rdata   (dmem_rdata),
        .dmem_resp    (dmem_resp)
    );

    //-------------------------------------------------
    // Shared bus
    //-------------------------------------------------

    // Only the port with its request bit high acts on it
    assign port_cmd   = dmem_cmd;
    assign port_width = dmem_width;
    assign port_addr  = dmem_addr;
    assign port_wdata = dmem_wdata;

endmodule

// File: sim/dmem_port_model.sv
//-------------------------------------------------
// Behavioral memory port for the router testbench
// Random acknowledge delay and response latency
// Read data is the address XOR a per-port pattern
// Bit 15 of the address forces an error response
//-------------------------------------------------

`timescale 1ns/100ps

module dmem_port_model #(
    parameter int PORT_ID = 0
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         req,
    input  dmem_router_pkg::mem_cmd_e    cmd,
    input  dmem_router_pkg::dmem_addr_t  addr,
    output logic                         req_ack,
    output dmem_router_pkg::mem_resp_e   resp,
    output dmem_router_pkg::dmem_data_t  rdata
);

    import dmem_router_pkg::*;

    // Cycles left before acknowledge, -1 when not drawn yet
    int         wait_cnt;
    // Cycles left before the response, 0 when idle
    int         lat_cnt;
    mem_resp_e  pend_resp;
    dmem_data_t pend_data;

    always @(posedge clk) begin
        if (!rst_n) begin
            req_ack  <= 1'b0;
            resp     <= RESP_NOTRDY;
            rdata    <= '0;
            wait_cnt = -1;
            lat_cnt  = 0;
        end else begin
            // Response is a single-cycle pulse
            resp <= RESP_NOTRDY;
            if (lat_cnt == 1) begin
                resp    <= pend_resp;
                rdata   <= pend_data;
                lat_cnt = 0;
            end else if (lat_cnt > 1) begin
                lat_cnt = lat_cnt - 1;
            end
            // Address handshake
            if (req && req_ack) begin
                req_ack   <= 1'b0;
                wait_cnt  = -1;
                pend_resp = addr[15] ? RESP_RDY_ER : RESP_RDY_OK;
                // Writes store nothing
                pend_data = (cmd == CMD_RD) ? (addr ^ (32'(PORT_ID) * 32'h1111_1111)) : '0;
                lat_cnt   = 1 + int'($urandom % 3);
            end else if (wait_cnt < 0) begin
                // Zero delay acknowledges ahead of the next request
                wait_cnt = int'($urandom % 4);
                req_ack  <= (wait_cnt == 0);
            end else if (req && wait_cnt > 0) begin
                wait_cnt = wait_cnt - 1;
                req_ack  <= (wait_cnt == 0);
            end
        end
    end

endmodule

// File: sim/dmem_router_assert.sv
//-------------------------------------------------
// Concurrent assertions on the router top level
// Request one-hot, request implies core request,
// no unknown bus fields while a request is up
//-------------------------------------------------

`timescale 1ns/100ps

module dmem_router_assert (
    input logic                         clk,
    input logic                         rst_n,
    input logic                         dmem_req,
    input logic                         dmem_cmd,
    input dmem_router_pkg::dmem_width_t dmem_width,
    input dmem_router_pkg::dmem_addr_t  dmem_addr,
    input dmem_router_pkg::port_vec_t   port_req
);

    // At most one port is addressed
    a_req_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(port_req))
        else $error("port_req has more than one bit set");

    // No port request without a core request
    a_req_from_core: assert property (@(posedge clk) disable iff (!rst_n)
        (|port_req) |-> dmem_req)
        else $error("port_req raised while dmem_req is low");

    // Bus fields known during a request
    a_bus_known: assert property (@(posedge clk) disable iff (!rst_n)
        dmem_req |-> !$isunknown({dmem_addr, dmem_cmd, dmem_width}))
        else $error("unknown address, command or width during a request");

endmodule

bind dmem_router dmem_router_assert u_dmem_router_assert (
    .clk        (clk),
    .rst_n      (rst_n),
    .dmem_req   (dmem_req),
    .dmem_cmd   (dmem_cmd),
    .dmem_width (dmem_width),
    .dmem_addr  (dmem_addr),
    .port_req   (port_req)
);

// File: sim/tb_dmem_router.sv
//-------------------------------------------------
// Testbench for the data memory router
// Clock, reset, five port models, stimulus table,
// response monitor, watchdog and summary
//-------------------------------------------------

`timescale 1ns/100ps

module tb_dmem_router;

    import dmem_router_pkg::*;

    localparam int  N_ROWS   = 13;
    localparam real CLK_NS   = 4.0;
    // Each row gets 12 cycles, plus the reset cycles
    localparam real LIMIT_NS = (2 + N_ROWS * 12) * CLK_NS;

    logic       clk;
    logic       rst_n;
    logic       dmem_req;
    mem_cmd_e   dmem_cmd;
    logic [1:0] dmem_width;
    dmem_addr_t dmem_addr;
    dmem_data_t dmem_wdata;
    logic       dmem_req_ack;
    dmem_data_t dmem_rdata;
    mem_resp_e  dmem_resp;
    port_vec_t  port_req;
    port_vec_t  port_req_ack;
    mem_cmd_e   port_cmd;
    logic [1:0] port_width;
    dmem_addr_t port_addr;
    dmem_data_t port_wdata;
    dmem_data_t [N_PORTS-1:0] port_rdata;
    mem_resp_e  [N_PORTS-1:0] port_resp;

    // Stimulus table
    string      row_name  [N_ROWS];
    dmem_addr_t row_addr  [N_ROWS];
    mem_cmd_e   row_cmd   [N_ROWS];
    dmem_data_t row_wdata [N_ROWS];
    int         row_port  [N_ROWS];
    mem_resp_e  row_resp  [N_ROWS];
    dmem_data_t row_rdata [N_ROWS];
    bit         row_burst [N_ROWS];
    int         row_errs  [N_ROWS];

    int         outstanding[$];
    int         issued;
    int         done_cnt;
    int         err_count;
    int         rows_ok;
    int         rows_bad;
    int         stall_cycles;

    always #(CLK_NS / 2) clk = ~clk;

    dmem_router u_dmem_router (.*);

    genvar g;
    generate
        for (g = 0; g < N_PORTS; g++) begin : g_port
            dmem_port_model #(.PORT_ID(g)) u_port (
                .clk     (clk),
                .rst_n   (rst_n),
                .req     (port_req[g]),
                .cmd     (port_cmd),
                .addr    (port_addr),
                .req_ack (port_req_ack[g]),
                .resp    (port_resp[g]),
                .rdata   (port_rdata[g])
            );
        end
    endgenerate

    //-------------------------------------------------
    // Helpers
    //-------------------------------------------------

    task automatic check_value(input int row, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        string name;
        name = (row >= 0) ? {row_name[row], " ", what} : what;
        if (expected !== actual) begin
            $display("** Error %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
            err_count++;
            if (row >= 0) begin
                row_errs[row]++;
            end
        end
    endtask

    // Port model rule for read data
    function automatic dmem_data_t rule_rdata(input dmem_addr_t addr, input int port);
        return addr ^ (32'(port) * 32'h1111_1111);
    endfunction

    task automatic set_row(input int i, input string name, input dmem_addr_t addr,
                           input mem_cmd_e cmd, input int port, input mem_resp_e resp,
                           input bit burst);
        row_name[i]  = name;
        row_addr[i]  = addr;
        row_cmd[i]   = cmd;
        row_wdata[i] = ~addr;
        row_port[i]  = port;
        row_resp[i]  = resp;
        row_rdata[i] = rule_rdata(addr, port);
        row_burst[i] = burst;
        row_errs[i]  = 0;
    endtask

    task automatic load_table();
        set_row(0,  "rd_port0",     32'h0000_1234, CMD_RD, 0, RESP_RDY_OK, 1'b0);
        set_row(1,  "rd_port1",     32'h0001_0040, CMD_RD, 1, RESP_RDY_OK, 1'b0);
        set_row(2,  "wr_port2",     32'h0002_0100, CMD_WR, 2, RESP_RDY_OK, 1'b0);
        set_row(3,  "rd_port3",     32'h0003_0FF0, CMD_RD, 3, RESP_RDY_OK, 1'b0);
        set_row(4,  "rd_port4",     32'h0004_0008, CMD_RD, 4, RESP_RDY_OK, 1'b0);
        set_row(5,  "rd_outside",   32'h0010_0000, CMD_RD, 0, RESP_RDY_OK, 1'b0);
        // Error, then a normal access right after
        set_row(6,  "rd_err_p2",    32'h0002_8000, CMD_RD, 2, RESP_RDY_ER, 1'b0);
        set_row(7,  "rd_after_err", 32'h0002_0004, CMD_RD, 2, RESP_RDY_OK, 1'b0);
        // Burst alternating between ports
        set_row(8,  "burst_p1_a",   32'h0001_0010, CMD_RD, 1, RESP_RDY_OK, 1'b1);
        set_row(9,  "burst_p3",     32'h0003_0020, CMD_RD, 3, RESP_RDY_OK, 1'b1);
        set_row(10, "burst_p1_b",   32'h0001_0030, CMD_RD, 1, RESP_RDY_OK, 1'b1);
        set_row(11, "burst_p4",     32'h0004_0040, CMD_RD, 4, RESP_RDY_OK, 1'b0);
        set_row(12, "wr_err_p4",    32'h0004_8004, CMD_WR, 4, RESP_RDY_ER, 1'b0);
    endtask

    //-------------------------------------------------
    // Response monitor
    //-------------------------------------------------

    always @(posedge clk) begin
        int r;
        if (rst_n && dmem_resp != RESP_NOTRDY) begin
            if (outstanding.size() == 0) begin
                $display("response seen with no access outstanding");
                err_count++;
            end else begin
                r = outstanding.pop_front();
                check_value(r, "resp", 32'(row_resp[r]), 32'(dmem_resp));
                if (row_cmd[r] == CMD_RD && row_resp[r] == RESP_RDY_OK) begin
                    check_value(r, "rdata", row_rdata[r], dmem_rdata);
                end
                if (row_errs[r] == 0) begin
                    rows_ok++;
                    $display("row %0d %s: ok", r, row_name[r]);
                end else begin
                    rows_bad++;
                    $display("row %0d %s: FAILED", r, row_name[r]);
                end
                done_cnt++;
            end
        end
    end

    //-------------------------------------------------
    // Watchdog
    //-------------------------------------------------

    initial begin
        #(LIMIT_NS);
        $display("timeout: transactions did not complete");
        $display("Something failed");
        $finish;
    end

    //-------------------------------------------------
    // Stimulus
    //-------------------------------------------------

    initial begin
        bit hs;
        clk          = 1'b0;
        rst_n        = 1'b0;
        dmem_req     = 1'b0;
        dmem_cmd     = CMD_RD;
        dmem_width   = 2'b10;
        dmem_addr    = '0;
        dmem_wdata   = '0;
        issued       = 0;
        done_cnt     = 0;
        err_count    = 0;
        rows_ok      = 0;
        rows_bad     = 0;
        stall_cycles = 0;
        void'($urandom(36503));
        load_table();

        // Reset, no request may leave during or after it
        repeat (2) begin
            @(posedge clk);
            check_value(-1, "port_req in reset", 32'h0, 32'(port_req));
        end
        @(negedge clk);
        rst_n = 1'b1;
        repeat (2) begin
            @(posedge clk);
            check_value(-1, "port_req after reset", 32'h0, 32'(port_req));
        end

        for (int r = 0; r < N_ROWS; r++) begin
            @(negedge clk);
            dmem_req   = 1'b1;
            dmem_cmd   = row_cmd[r];
            dmem_width = dmem_width_t'(r % 3);
            dmem_addr  = row_addr[r];
            dmem_wdata = row_wdata[r];
            hs = 1'b0;
            while (!hs) begin
                @(posedge clk);
                if (dmem_req_ack) begin
                    hs = 1'b1;
                    check_value(r, "port_req", 32'(1 << row_port[r]), 32'(port_req));
                    // Shared bus is the core request unchanged
                    check_value(r, "port_addr", row_addr[r], port_addr);
                    check_value(r, "port_cmd", 32'(row_cmd[r]), 32'(port_cmd));
                    check_value(r, "port_width", 32'(r % 3), 32'(port_width));
                    check_value(r, "port_wdata", row_wdata[r], port_wdata);
                    outstanding.push_back(r);
                    issued++;
                end else if (done_cnt == issued && !port_req_ack[row_port[r]]) begin
                    // Target holds off, request stays up
                    stall_cycles++;
                    check_value(r, "port_req held", 32'(1 << row_port[r]), 32'(port_req));
                end
            end
            if (!row_burst[r]) begin
                @(negedge clk);
                dmem_req = 1'b0;
                while (done_cnt < issued) begin
                    @(posedge clk);
                end
            end
        end

        $display("rows passed %0d, rows failed %0d, errors %0d, stall cycles %0d",
                 rows_ok, rows_bad, err_count, stall_cycles);
        if (err_count == 0 && rows_bad == 0 && done_cnt == N_ROWS) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: tb.f
design/dmem_router_pkg.sv
design/dmem_addr_decoder.sv
design/dmem_req_steer.sv
design/dmem_txn_tracker.sv
design/dmem_router.sv
sim/dmem_port_model.sv
sim/dmem_router_assert.sv
sim/tb_dmem_router.sv

// File: run.sh
#!/bin/sh
# Build and run the router testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_dmem_router \
    -f tb.f --Mdir obj_dir -o sim_tb > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }

./obj_dir/sim_tb > sim.log 2>&1
grep -q "^Everything OK$" sim.log && echo "PASS" \
    || { echo "FAIL, see sim.log"; exit 1; }
